// File: hw/tcb_lite_pkg.sv
/*
  shared widths and enums for the TCB-Lite subsystem
  data width is fixed at 32 bits with little-endian byte lanes
  transfer size is a power of two bytes, siz_dword is illegal at this width
*/

package tcb_lite_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // bus data width in bits
    localparam int unsigned tcb_lite_data_width = 32;
    // bytes per bus word
    localparam int unsigned tcb_lite_byte_count = tcb_lite_data_width / 8;
    // low address bits that select a byte lane
    localparam int unsigned tcb_lite_offset_width = $clog2(tcb_lite_byte_count);

    //////////////////////////////////////////////////////////////////////
    // transfer size
    //////////////////////////////////////////////////////////////////////

    // log2 of the number of bytes in a transfer
    typedef enum logic [1:0] {
        siz_byte  = 2'd0,
        siz_half  = 2'd1,
        siz_word  = 2'd2,
        siz_dword = 2'd3
    } tcb_lite_siz_t;

    // largest size that fits in one bus word
    localparam tcb_lite_siz_t tcb_lite_size_max = siz_word;

    //////////////////////////////////////////////////////////////////////
    // protocol checker codes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        viol_none          = 3'd0,
        // vld seen while reset was high
        viol_reset_valid   = 3'd1,
        // vld seen in the first cycle out of reset
        viol_reset_release = 3'd2,
        // request fields moved during a stall
        viol_unstable      = 3'd3,
        // siz wider than the bus
        viol_size_range    = 3'd4
    } tcb_lite_viol_t;

endpackage

// File: hw/tcb_lite_lane_aligner.sv
/*
  combinational size/address to byte lane conversion
  misaligned or oversized requests keep going with no byte enables
  and req_err set, so they still get an in-order error response
*/

`timescale 1ns/1ps

module tcb_lite_lane_aligner import tcb_lite_pkg::*; #(
    parameter int unsigned addr_width = 8
) (
    // external request
    input  logic                                     vld,
    input  logic [addr_width-1:0]                    adr,
    input  tcb_lite_siz_t                            siz,
    input  logic                                     wen,
    input  logic [tcb_lite_data_width-1:0]           wdt,
    output logic                                     rdy,
    // aligned request to the queue
    output logic                                     req_vld,
    output logic                                     req_wen,
    output logic [addr_width-tcb_lite_offset_width-1:0] req_adr,
    output logic [tcb_lite_byte_count-1:0]           req_byt,
    output logic [tcb_lite_data_width-1:0]           req_wdt,
    output logic                                     req_err,
    input  logic                                     req_rdy
);

    logic [tcb_lite_offset_width-1:0] off;
    logic [tcb_lite_byte_count-1:0]   lane_mask;
    logic                             misaligned;
    logic                             too_wide;

    // handshake goes straight through
    assign req_vld = vld;
    assign rdy     = req_rdy;
    assign req_wen = wen;

    // byte offset inside the word, rest is the word address
    assign off     = adr[tcb_lite_offset_width-1:0];
    assign req_adr = adr[addr_width-1:tcb_lite_offset_width];

    always_comb begin
        // 2^siz lanes starting at lane 0
        for (int i = 0; i < tcb_lite_byte_count; i++) begin
            lane_mask[i] = (i < (1 << siz));
        end
        // any offset bit below the size makes it misaligned
        misaligned = 1'b0;
        for (int i = 0; i < tcb_lite_offset_width; i++) begin
            if (off[i] && (i < siz)) begin
                misaligned = 1'b1;
            end
        end
    end

    assign too_wide = (siz > tcb_lite_size_max);
    assign req_err  = misaligned || too_wide;

    // move the enables and the low data bytes up to the addressed lane
    assign req_byt = req_err ? '0 : (lane_mask << off);
    assign req_wdt = wdt << {off, 3'b000};

endmodule

// File: hw/tcb_lite_request_queue.sv
/*
  two-entry request FIFO, no bypass
  a request written on one edge is offered on the next cycle
  in_rdy stays high while at least one slot is free
*/

`timescale 1ns/1ps

module tcb_lite_request_queue import tcb_lite_pkg::*; #(
    parameter int unsigned addr_width = 8,
    localparam int unsigned word_width = addr_width - tcb_lite_offset_width
) (
    input  logic                           tcb,
    input  logic                           reset,
    // write side, from the aligner
    input  logic                           in_vld,
    output logic                           in_rdy,
    input  logic                           in_wen,
    input  logic [word_width-1:0]          in_adr,
    input  logic [tcb_lite_byte_count-1:0] in_byt,
    input  logic [tcb_lite_data_width-1:0] in_wdt,
    input  logic                           in_err,
    // read side, to the memory
    output logic                           out_vld,
    input  logic                           out_rdy,
    output logic                           out_wen,
    output logic [word_width-1:0]          out_adr,
    output logic [tcb_lite_byte_count-1:0] out_byt,
    output logic [tcb_lite_data_width-1:0] out_wdt,
    output logic                           out_err
);

    // wen, err, word address, enables, data
    localparam int unsigned entry_width =
        2 + word_width + tcb_lite_byte_count + tcb_lite_data_width;

    logic [entry_width-1:0] slot [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic                   wr_en;
    logic                   rd_en;

    assign in_rdy  = (count != 2'd2);
    assign out_vld = (count != 2'd0);
    assign wr_en   = in_vld && in_rdy;
    assign rd_en   = out_vld && out_rdy;

    // pointers and fill level
    always_ff @(posedge tcb) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (wr_en) begin
                wr_ptr <= !wr_ptr;
            end
            if (rd_en) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + 2'(wr_en) - 2'(rd_en);
        end
    end

    // payload slots
    always_ff @(posedge tcb) begin
        if (wr_en) begin
            slot[wr_ptr] <= {in_wen, in_err, in_adr, in_byt, in_wdt};
        end
    end

    assign {out_wen, out_err, out_adr, out_byt, out_wdt} = slot[rd_ptr];

    // a push must never land on the entry still on offer
    a_no_overflow: assert property (@(posedge tcb) disable iff (reset)
        out_vld && !out_rdy |=> out_vld &&
            $stable({out_wen, out_err, out_adr, out_byt, out_wdt}))
        else $error("request queue overwrote a waiting entry");

    // read and write pointers track the fill level
    a_no_underflow: assert property (@(posedge tcb) disable iff (reset)
        count != 2'd3 && count[0] == (wr_ptr ^ rd_ptr))
        else $error("request queue pointers disagree with its level");

endmodule

// File: hw/tcb_lite_memory.sv
/*
  word array with byte enables, 2^(addr_width-2) words, contents start undefined
  hold high stalls execution, a request executes when mem_vld && !hold
  response is registered and valid for one cycle after execution
  reads return the whole word as it was before a same-edge write
*/

`timescale 1ns/1ps

module tcb_lite_memory import tcb_lite_pkg::*; #(
    parameter int unsigned addr_width = 8,
    localparam int unsigned word_width = addr_width - tcb_lite_offset_width
) (
    input  logic                           tcb,
    input  logic                           reset,
    input  logic                           hold,
    // request from the queue
    input  logic                           mem_vld,
    output logic                           mem_rdy,
    input  logic                           mem_wen,
    input  logic [word_width-1:0]          mem_adr,
    input  logic [tcb_lite_byte_count-1:0] mem_byt,
    input  logic [tcb_lite_data_width-1:0] mem_wdt,
    input  logic                           mem_err,
    // response strobe
    output logic                           rsp_vld,
    output logic [tcb_lite_data_width-1:0] rdt,
    output logic                           err
);

    logic [tcb_lite_data_width-1:0] mem [2**word_width];
    logic                           exec;

    assign mem_rdy = !hold;
    assign exec    = mem_vld && mem_rdy;

    // write only the enabled lanes, errored requests never touch the array
    always_ff @(posedge tcb) begin
        if (exec && mem_wen && !mem_err) begin
            for (int i = 0; i < tcb_lite_byte_count; i++) begin
                if (mem_byt[i]) begin
                    mem[mem_adr][8*i +: 8] <= mem_wdt[8*i +: 8];
                end
            end
        end
    end

    // response payload
    always_ff @(posedge tcb) begin
        if (exec) begin
            rdt <= mem[mem_adr];
            err <= mem_err;
        end
    end

    // strobe
    always_ff @(posedge tcb) begin
        if (reset) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= exec;
        end
    end

    // a held edge leaves the offered word untouched
    a_hold_blocks: assert property (@(posedge tcb) disable iff (reset)
        hold |=> mem[$past(mem_adr)] === $past(mem[mem_adr]))
        else $error("memory written during hold");

    // queue keeps the stalled request on offer until hold releases
    a_hold_keeps: assert property (@(posedge tcb) disable iff (reset)
        hold && mem_vld |=> mem_vld)
        else $error("stalled memory request withdrawn");

endmodule

// File: hw/tcb_lite_protocol_checker.sv
/*
  passive monitor on the external request port
  first rule break is latched in viol_code until the next reset
  no X checks, lock or endianness rules
  assertions mirror the code, tests that break rules on purpose turn them off
*/

`timescale 1ns/1ps

module tcb_lite_protocol_checker import tcb_lite_pkg::*; #(
    parameter int unsigned addr_width = 8
) (
    input  logic                           tcb,
    input  logic                           reset,
    input  logic                           vld,
    input  logic                           rdy,
    input  logic                           wen,
    input  logic [addr_width-1:0]          adr,
    input  tcb_lite_siz_t                  siz,
    input  logic [tcb_lite_data_width-1:0] wdt,
    output logic                           viol,
    output tcb_lite_viol_t                 viol_code
);

    //////////////////////////////////////////////////////////////////////
    // history
    //////////////////////////////////////////////////////////////////////

    logic                           reset_q;
    logic                           rst_vld;
    logic                           stl_q;
    logic                           wen_q;
    logic [addr_width-1:0]          adr_q;
    tcb_lite_siz_t                  siz_q;
    logic [tcb_lite_data_width-1:0] wdt_q;
    tcb_lite_viol_t                 det_code;

    always_ff @(posedge tcb) begin
        reset_q <= reset;
        // collects vld over the whole reset, reported once it ends
        if (reset) begin
            rst_vld <= rst_vld || vld;
            stl_q   <= 1'b0;
        end else begin
            rst_vld <= 1'b0;
            stl_q   <= vld && !rdy;
        end
    end

    // fields of the previous cycle, compared only after a stall
    always_ff @(posedge tcb) begin
        wen_q <= wen;
        adr_q <= adr;
        siz_q <= siz;
        wdt_q <= wdt;
    end

    //////////////////////////////////////////////////////////////////////
    // detection and latch
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        det_code = viol_none;
        if (vld) begin
            if (reset_q && !reset) begin
                det_code = viol_reset_release;
            end else if (stl_q && (wen != wen_q || adr != adr_q ||
                                   siz != siz_q || wdt != wdt_q)) begin
                det_code = viol_unstable;
            end else if (siz > tcb_lite_size_max) begin
                det_code = viol_size_range;
            end
        end
        // the reset one happened earliest, so it wins
        if (rst_vld && !reset) begin
            det_code = viol_reset_valid;
        end
    end

    always_ff @(posedge tcb) begin
        if (reset) begin
            viol      <= 1'b0;
            viol_code <= viol_none;
        end else if (!viol && det_code != viol_none) begin
            viol      <= 1'b1;
            viol_code <= det_code;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // assertions
    //////////////////////////////////////////////////////////////////////

    a_reset_valid: assert property (@(posedge tcb) reset |-> !vld)
        else $error("vld high during reset");

    a_reset_release: assert property (@(posedge tcb) $fell(reset) |-> !vld)
        else $error("vld high in the first cycle after reset");

    // stalled request must not move until it is taken
    a_stable: assert property (@(posedge tcb) disable iff (reset)
        vld && $past(vld && !rdy) |-> $stable({wen, adr, siz, wdt}))
        else $error("request changed during a stall");

    a_size: assert property (@(posedge tcb) disable iff (reset)
        vld |-> siz <= tcb_lite_size_max)
        else $error("transfer size out of range");

endmodule

// File: hw/tcb_lite_subsystem.sv
/*
  TCB-Lite subordinate, aligner -> two-entry queue -> memory
  read latency is 2 cycles with hold low, longer under hold
  responses are strobes in request order with no back-pressure
*/

`timescale 1ns/1ps

module tcb_lite_subsystem import tcb_lite_pkg::*; #(
    parameter int unsigned addr_width = 8
) (
    input  logic                           tcb,
    input  logic                           reset,
    input  logic                           hold,
    // request
    input  logic                           vld,
    output logic                           rdy,
    input  logic                           wen,
    input  logic [addr_width-1:0]          adr,
    input  tcb_lite_siz_t                  siz,
    input  logic [tcb_lite_data_width-1:0] wdt,
    // response
    output logic                           rsp_vld,
    output logic [tcb_lite_data_width-1:0] rdt,
    output logic                           err,
    // monitor
    output logic                           viol,
    output tcb_lite_viol_t                 viol_code
);

    localparam int unsigned word_width = addr_width - tcb_lite_offset_width;

    // aligner to queue
    logic                           req_vld;
    logic                           req_rdy;
    logic                           req_wen;
    logic [word_width-1:0]          req_adr;
    logic [tcb_lite_byte_count-1:0] req_byt;
    logic [tcb_lite_data_width-1:0] req_wdt;
    logic                           req_err;

    // queue to memory
    logic                           mem_vld;
    logic                           mem_rdy;
    logic                           mem_wen;
    logic [word_width-1:0]          mem_adr;
    logic [tcb_lite_byte_count-1:0] mem_byt;
    logic [tcb_lite_data_width-1:0] mem_wdt;
    logic                           mem_err;

    tcb_lite_lane_aligner #(.addr_width(addr_width)) u_aligner (
        .vld(vld), .adr(adr), .siz(siz), .wen(wen), .wdt(wdt), .rdy(rdy),
        .req_vld(req_vld), .req_wen(req_wen), .req_adr(req_adr),
        .req_byt(req_byt), .req_wdt(req_wdt), .req_err(req_err),
        .req_rdy(req_rdy)
    );

    tcb_lite_request_queue #(.addr_width(addr_width)) u_queue (
        .tcb(tcb), .reset(reset),
        .in_vld(req_vld), .in_rdy(req_rdy), .in_wen(req_wen),
        .in_adr(req_adr), .in_byt(req_byt), .in_wdt(req_wdt),
        .in_err(req_err),
        .out_vld(mem_vld), .out_rdy(mem_rdy), .out_wen(mem_wen),
        .out_adr(mem_adr), .out_byt(mem_byt), .out_wdt(mem_wdt),
        .out_err(mem_err)
    );

    tcb_lite_memory #(.addr_width(addr_width)) u_memory (
        .tcb(tcb), .reset(reset), .hold(hold),
        .mem_vld(mem_vld), .mem_rdy(mem_rdy), .mem_wen(mem_wen),
        .mem_adr(mem_adr), .mem_byt(mem_byt), .mem_wdt(mem_wdt),
        .mem_err(mem_err),
        .rsp_vld(rsp_vld), .rdt(rdt), .err(err)
    );

    // sits on the external port only
    tcb_lite_protocol_checker #(.addr_width(addr_width)) u_checker (
        .tcb(tcb), .reset(reset),
        .vld(vld), .rdy(rdy), .wen(wen), .adr(adr), .siz(siz), .wdt(wdt),
        .viol(viol), .viol_code(viol_code)
    );

endmodule

// File: verification/tcb_lite_subsystem_tb.sv
/*
  file-driven testbench for the TCB-Lite subsystem, addr_width 8
  stimulus comes from verification/tcb_lite_tests.txt, run from the project root
  reads only touch words that were fully written earlier
  checker assertions are switched off around deliberate rule breaks
*/

`timescale 1ns/1ps

module tcb_lite_subsystem_tb import tcb_lite_pkg::*; ;

    localparam int unsigned addr_width = 8;
    localparam int timeout_cycles = 40;

    logic                           tcb = 1'b0;
    logic                           reset;
    logic                           hold;
    logic                           vld;
    logic                           rdy;
    logic                           wen;
    logic [addr_width-1:0]          adr;
    tcb_lite_siz_t                  siz;
    logic [tcb_lite_data_width-1:0] wdt;
    logic                           rsp_vld;
    logic [tcb_lite_data_width-1:0] rdt;
    logic                           err;
    logic                           viol;
    tcb_lite_viol_t                 viol_code;

    // reference bytes, little-endian lanes
    logic [7:0] ref_mem [2**addr_width];

    // expected responses in request order
    logic [31:0] exp_data [$];
    logic        exp_err [$];
    logic        exp_chk [$];
    int          exp_acc [$];

    int   cyc = 0;
    int   hold_cyc = -1;
    int   last_rsp = -10;
    logic watch_viol = 1'b0;

    tcb_lite_subsystem #(.addr_width(addr_width)) dut (
        .tcb(tcb), .reset(reset), .hold(hold),
        .vld(vld), .rdy(rdy), .wen(wen), .adr(adr), .siz(siz), .wdt(wdt),
        .rsp_vld(rsp_vld), .rdt(rdt), .err(err),
        .viol(viol), .viol_code(viol_code)
    );

    always #2 tcb = ~tcb;

    // edge counter, remembers the last edge that saw hold
    always @(posedge tcb) begin
        cyc <= cyc + 1;
        if (hold) begin
            hold_cyc <= cyc + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // failure and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %0t %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %0t %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_viol(input string name, input tcb_lite_viol_t got,
                              input tcb_lite_viol_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %0t %s got %s expected %s",
                                    $time, name, got.name(), exp.name()));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // response monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge tcb) begin
        int due;
        int rsp_edge;
        if (!reset) begin
            if (watch_viol && viol) begin
                stop_on_error("viol went high during a clean sequence");
            end
            if (rsp_vld) begin
                if (exp_err.size() == 0) begin
                    stop_on_error("response strobe with no request outstanding");
                end
                // the next rising edge samples this strobe
                rsp_edge = cyc + 1;
                // with no hold since acceptance the memory runs one per cycle
                due = (exp_acc[0] + 2 > last_rsp + 1) ? exp_acc[0] + 2 : last_rsp + 1;
                if (hold_cyc <= exp_acc[0] && rsp_edge != due) begin
                    stop_on_error($sformatf("response at edge %0d, due at edge %0d",
                                            rsp_edge, due));
                end
                check_err("err", err, exp_err[0]);
                if (exp_chk[0]) begin
                    check_data("rdt", rdt, exp_data[0]);
                end
                void'(exp_data.pop_front());
                void'(exp_err.pop_front());
                void'(exp_chk.pop_front());
                void'(exp_acc.pop_front());
                last_rsp = rsp_edge;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // drive one request, optionally held stalled under hold first
    task automatic send(input logic h, input logic w, input logic [1:0] s,
                        input logic [7:0] a, input logic [31:0] d, input logic e,
                        input int stall);
        int t;
        int acc;
        logic [31:0] word;
        hold = h;
        vld  = 1'b1;
        wen  = w;
        siz  = tcb_lite_siz_t'(s);
        adr  = a;
        wdt  = d;
        if (stall > 0) begin
            repeat (stall) begin
                if (rdy) begin
                    stop_on_error("rdy high although two requests wait under hold");
                end
                @(negedge tcb);
            end
            hold = 1'b0;
        end else if (h && !rdy) begin
            stop_on_error("rdy low before two requests were queued");
        end
        t = 0;
        while (!rdy) begin
            @(negedge tcb);
            t++;
            if (t > timeout_cycles) begin
                stop_on_error("timeout waiting for rdy");
            end
        end
        @(negedge tcb);
        acc = cyc;
        vld = 1'b0;
        // word as it stands before this request
        word = {ref_mem[{a[7:2], 2'd3}], ref_mem[{a[7:2], 2'd2}],
                ref_mem[{a[7:2], 2'd1}], ref_mem[{a[7:2], 2'd0}]};
        if (w && !e) begin
            for (int i = 0; i < (1 << s); i++) begin
                ref_mem[a + i] = d[8*i +: 8];
            end
        end
        exp_data.push_back(word);
        exp_err.push_back(e);
        exp_chk.push_back(!w && !e);
        exp_acc.push_back(acc);
    endtask

    task automatic drain;
        int t;
        t = 0;
        while (exp_err.size() != 0) begin
            @(negedge tcb);
            t++;
            if (t > timeout_cycles) begin
                stop_on_error("timeout waiting for outstanding responses");
            end
        end
    endtask

    task automatic apply_reset;
        reset = 1'b1;
        vld   = 1'b0;
        // hold stays for the first reset edge so queued writes never run
        @(negedge tcb);
        hold = 1'b0;
        repeat (3) @(negedge tcb);
        reset = 1'b0;
        @(negedge tcb);
        if (!rdy) begin
            stop_on_error("rdy low after reset");
        end
        if (rsp_vld) begin
            stop_on_error("rsp_vld high after reset");
        end
        check_viol("viol_code", viol_code, viol_none);
        if (exp_err.size() != 0) begin
            stop_on_error("responses still outstanding across a reset");
        end
    endtask

    initial begin
        int fd;
        int t;
        string line;
        logic [31:0] op, h, w, s, a, d, e;
        reset = 1'b1;
        hold  = 1'b0;
        vld   = 1'b0;
        wen   = 1'b0;
        adr   = '0;
        siz   = siz_byte;
        wdt   = '0;
        repeat (4) @(negedge tcb);
        reset = 1'b0;
        @(negedge tcb);
        watch_viol = 1'b1;

        fd = $fopen("verification/tcb_lite_tests.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open verification/tcb_lite_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h %h %h %h", op, h, w, s, a, d, e) == 7) begin
                case (op)
                    0: send(h[0], w[0], s[1:0], a[7:0], d, e[0], 0);
                    1: send(1'b1, w[0], s[1:0], a[7:0], d, e[0], 3);
                    2: drain();
                    // adr moves while the third request is stalled
                    3: begin
                        $assertoff;
                        watch_viol = 1'b0;
                        hold = 1'b1;
                        vld  = 1'b1;
                        wen  = w[0];
                        siz  = tcb_lite_siz_t'(s[1:0]);
                        adr  = a[7:0];
                        wdt  = d;
                        t = 0;
                        while (rdy) begin
                            @(negedge tcb);
                            t++;
                            if (t > timeout_cycles) begin
                                stop_on_error("timeout waiting for a stall");
                            end
                        end
                        @(negedge tcb);
                        adr = adr ^ 8'h04;
                        @(negedge tcb);
                        check_viol("viol_code", viol_code, tcb_lite_viol_t'(e[2:0]));
                        vld = 1'b0;
                    end
                    // vld right as reset drops
                    4: begin
                        $assertoff;
                        watch_viol = 1'b0;
                        hold  = 1'b1;
                        reset = 1'b1;
                        repeat (4) @(negedge tcb);
                        reset = 1'b0;
                        vld   = 1'b1;
                        wen   = w[0];
                        siz   = tcb_lite_siz_t'(s[1:0]);
                        adr   = a[7:0];
                        @(negedge tcb);
                        check_viol("viol_code", viol_code, tcb_lite_viol_t'(e[2:0]));
                        vld = 1'b0;
                    end
                    // vld pulse in the middle of reset
                    5: begin
                        $assertoff;
                        watch_viol = 1'b0;
                        reset = 1'b1;
                        vld   = 1'b1;
                        @(negedge tcb);
                        vld = 1'b0;
                        repeat (3) @(negedge tcb);
                        reset = 1'b0;
                        @(negedge tcb);
                        check_viol("viol_code", viol_code, tcb_lite_viol_t'(e[2:0]));
                    end
                    // siz_dword always answers with err
                    6: begin
                        $assertoff;
                        watch_viol = 1'b0;
                        send(1'b0, w[0], 2'd3, a[7:0], d, 1'b1, 0);
                        check_viol("viol_code", viol_code, tcb_lite_viol_t'(e[2:0]));
                    end
                    7: begin
                        apply_reset();
                        $asserton;
                        watch_viol = 1'b1;
                    end
                    default: stop_on_error($sformatf("unknown operation %0d", op));
                endcase
            end
        end
        $fclose(fd);
        drain();
        if (exp_err.size() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verification/tcb_lite_tests.txt
# columns, all hex: op hold wen siz adr wdt err (err holds the viol code for ops 3-6)
# op 0 request, 1 stalled request, 2 drain, 3 unstable, 4 reset release, 5 reset valid,
# op 6 size range, 7 reset
# byte, half and word writes merged, then read back
0 0 1 2 10 11223344 0
0 0 1 0 11 000000aa 0
0 0 1 1 12 0000bbcc 0
0 0 0 2 10 00000000 0
0 0 1 2 20 deadbeef 0
0 0 1 0 23 0000005a 0
0 0 0 2 20 00000000 0
2 0 0 0 00 00000000 0
# misaligned half and word, memory must stay as it was
0 0 1 1 21 0000ffff 1
0 0 1 2 22 12345678 1
0 0 0 1 13 00000000 1
0 0 0 2 20 00000000 0
2 0 0 0 00 00000000 0
# two accepted under hold, third stalls until hold falls
0 1 1 2 30 01010101 0
0 1 1 2 34 02020202 0
1 1 1 2 38 03030303 0
0 0 0 2 30 00000000 0
0 0 0 2 34 00000000 0
0 0 0 2 38 00000000 0
2 0 0 0 00 00000000 0
# back-to-back without hold
0 0 1 2 40 a0a0a0a0 0
0 0 1 2 44 b1b1b1b1 0
0 0 1 1 46 0000c2c2 0
0 0 1 2 48 d3d3d3d3 0
0 0 0 2 40 00000000 0
0 0 0 2 44 00000000 0
0 0 0 2 48 00000000 0
0 0 0 2 10 00000000 0
2 0 0 0 00 00000000 0
# deliberate rule breaks, each followed by a reset
3 1 1 2 50 11111111 3
7 0 0 0 00 00000000 0
4 1 0 2 50 00000000 2
7 0 0 0 00 00000000 0
5 0 0 0 00 00000000 1
7 0 0 0 00 00000000 0
6 0 1 3 20 ffffffff 4
2 0 0 0 00 00000000 0
7 0 0 0 00 00000000 0
# dword write left the word alone
0 0 0 2 20 00000000 0
2 0 0 0 00 00000000 0

// File: vlog.f
hw/tcb_lite_pkg.sv
hw/tcb_lite_lane_aligner.sv
hw/tcb_lite_request_queue.sv
hw/tcb_lite_memory.sv
hw/tcb_lite_protocol_checker.sv
hw/tcb_lite_subsystem.sv
verification/tcb_lite_subsystem_tb.sv

// File: Makefile
SRCS := $(shell cat vlog.f)
SIM  := obj_dir/Vtcb_lite_subsystem_tb

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tcb_lite_subsystem_tb -f vlog.f -o Vtcb_lite_subsystem_tb

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
